/* design/job_dispatch.sv */
/*
  Job dispatcher
  Round-robin pointer, start pulse to the pointed-to idle lane
*/
`timescale 1ns/1ps
`default_nettype none

`include "mont_config.svh"

module job_dispatch
  import mont_pkg::*;
(
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic                       i_job_val,
  input  mont_opnd_t                 i_job_opnd,
  input  mont_cnt_t                  i_job_cnt,
  input  logic [`MONT_NUM_LANES-1:0] i_lane_idle,
  output logic                       o_job_rdy,
  output logic [`MONT_NUM_LANES-1:0] o_lane_start,
  output mont_opnd_t                 o_opnd,
  output mont_cnt_t                  o_cnt
);

  localparam lane_idx_t LAST_LANE = lane_idx_t'(`MONT_NUM_LANES - 1);

  // Next lane to receive a job
  lane_idx_t ptr;
  logic      job_xfer;

  // Ready follows the pointed-to lane
  assign o_job_rdy = i_lane_idle[ptr];
  assign job_xfer  = i_job_val && o_job_rdy;

  // One-hot start, only on a transfer
  always_comb begin
    o_lane_start = '0;
    if (job_xfer) begin
      o_lane_start[ptr] = 1'b1;
    end
  end

  // Shared buses, only the started lane latches
  assign o_opnd = i_job_opnd;
  assign o_cnt  = i_job_cnt;

  // Pointer moves on each accepted job
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ptr <= '0;
    end else if (job_xfer) begin
      ptr <= (ptr == LAST_LANE) ? '0 : ptr + lane_idx_t'(1);
    end
  end

endmodule

`default_nettype wire

/* design/mont_config.svh */
/*
  Build-time settings for the Montgomery squaring subsystem
  Word geometry, lane count, count width, modulus and factor
*/
`ifndef MONT_CONFIG_SVH
`define MONT_CONFIG_SVH

// Multiplier word geometry, R = 2^(words * bits)
`define MONT_WRD_BITS 32
`define MONT_NUM_WRDS 4

// Parallel squaring lanes
`define MONT_NUM_LANES 4

// Width of the squaring count
`define MONT_CNT_BITS 16

// Odd modulus p = 2^127 - 1, below 2^127
`define MONT_MODULUS 128'h7FFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF_FFFF

// Negated inverse of p mod R
`define MONT_FACTOR 128'h8000_0000_0000_0000_0000_0000_0000_0001

`endif

/* design/mont_pkg.sv */
/*
  Shared types for the Montgomery squaring subsystem
  Word, operand, product, count and lane index vectors
  Multiplier mode and lane state enums
*/
`default_nettype none

`include "mont_config.svh"

package mont_pkg;

  // One multiplier word
  typedef logic [`MONT_WRD_BITS-1:0] mont_word_t;

  // Operand, all words packed, LSW at bit 0
  typedef logic [`MONT_NUM_WRDS*`MONT_WRD_BITS-1:0] mont_opnd_t;

  // Double-width product
  typedef logic [2*`MONT_NUM_WRDS*`MONT_WRD_BITS-1:0] mont_prod_t;

  // Squaring count
  typedef logic [`MONT_CNT_BITS-1:0] mont_cnt_t;

  // Lane index, at least one bit wide
  typedef logic [(`MONT_NUM_LANES > 1 ? $clog2(`MONT_NUM_LANES) : 1)-1:0] lane_idx_t;

  // One-hot multiplier mode
  typedef enum logic [2:0] {
    SQR   = 3'b001,
    MUL_L = 3'b010,
    MUL_H = 3'b100
  } mult_mode_t;

  // Lane FSM, one squaring is SQR -> RED_L -> RED_H -> FIX
  typedef enum logic [2:0] {
    LANE_IDLE,
    LANE_SQR,
    LANE_RED_L,
    LANE_RED_H,
    LANE_FIX,
    LANE_DONE
  } lane_state_t;

endpackage

`default_nettype wire

/* design/mont_sq_lane.sv */
/*
  One squaring lane
  FSM running t Montgomery squarings on a latched operand
  Conditional subtraction per squaring, result held until release
*/
`timescale 1ns/1ps
`default_nettype none

`include "mont_config.svh"

module mont_sq_lane
  import mont_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_start,
  input  mont_opnd_t i_opnd,
  input  mont_cnt_t  i_cnt,
  input  logic       i_release,
  output logic       o_idle,
  output logic       o_done,
  output mont_opnd_t o_res
);

  localparam int OB = `MONT_NUM_WRDS * `MONT_WRD_BITS;

  // FSM
  lane_state_t state;
  lane_state_t state_nxt;

  // Remaining squarings
  mont_cnt_t cnt;

  // Working value, holds result in DONE
  mont_opnd_t work;

  // High half of T plus carry of the low-half sum
  mont_opnd_t add_r;

  // Multiplier hookup
  mult_mode_t mul_mode;
  mont_opnd_t mul_a;
  mont_opnd_t mul_b;
  mont_prod_t mul_out;
  mont_opnd_t prod_lo;
  mont_opnd_t prod_hi;

  // Final reduction step
  mont_opnd_t red_sub;
  logic       red_ge_p;

  logic start_acc;

  assign start_acc = (state == LANE_IDLE) && i_start;

  assign prod_lo = mul_out[OB-1:0];
  assign prod_hi = mul_out[2*OB-1:OB];

  // Sum below 2p, so one subtraction is enough
  assign red_sub  = prod_lo - `MONT_MODULUS;
  assign red_ge_p = (prod_lo >= `MONT_MODULUS);

  // Multiplier inputs per state
  always_comb begin
    mul_a    = work;
    mul_b    = work;
    mul_mode = SQR;
    case (state)
      LANE_RED_L: begin
        // m = T_lo * factor mod R
        mul_a    = prod_lo;
        mul_b    = `MONT_FACTOR;
        mul_mode = MUL_L;
      end
      LANE_RED_H: begin
        // (m * p) / R plus T_hi plus carry
        mul_a    = prod_lo;
        mul_b    = `MONT_MODULUS;
        mul_mode = MUL_H;
      end
      default: begin
        mul_mode = SQR;
      end
    endcase
  end

  // Next state
  always_comb begin
    state_nxt = state;
    case (state)
      LANE_IDLE: begin
        // Zero count skips straight to DONE
        if (i_start) begin
          state_nxt = (i_cnt == '0) ? LANE_DONE : LANE_SQR;
        end
      end
      LANE_SQR:   state_nxt = LANE_RED_L;
      LANE_RED_L: state_nxt = LANE_RED_H;
      LANE_RED_H: state_nxt = LANE_FIX;
      LANE_FIX: begin
        state_nxt = (cnt == mont_cnt_t'(1)) ? LANE_DONE : LANE_SQR;
      end
      LANE_DONE: begin
        if (i_release) begin
          state_nxt = LANE_IDLE;
        end
      end
      default: state_nxt = LANE_IDLE;
    endcase
  end

  // Control state
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= LANE_IDLE;
      cnt    <= '0;
      o_done <= 1'b0;
    end else begin
      state <= state_nxt;
      // Done flag one cycle behind DONE, drops on release
      o_done <= (state == LANE_DONE) && !i_release;
      if (start_acc) begin
        cnt <= i_cnt;
      end else if (state == LANE_FIX) begin
        cnt <= cnt - mont_cnt_t'(1);
      end
    end
  end

  // Payload
  always_ff @(posedge i_clk) begin
    if (start_acc) begin
      work <= i_opnd;
    end else if (state == LANE_FIX) begin
      work <= red_ge_p ? red_sub : prod_lo;
    end
    // T_lo + (m*p)_lo is 0 mod R, carries out unless T_lo is zero
    if (state == LANE_RED_L) begin
      add_r <= prod_hi + mont_opnd_t'(prod_lo != '0);
    end
  end

  assign o_idle = (state == LANE_IDLE);
  assign o_res  = work;

  word_multiplier u_mult (
    .i_clk      (i_clk),
    .i_mode     (mul_mode),
    .i_dat_a    (mul_a),
    .i_dat_b    (mul_b),
    .i_add_term (add_r),
    .o_dat      (mul_out)
  );

endmodule

`default_nettype wire

/* design/mont_sq_top.sv */
/*
  Repeated Montgomery squaring, top level
  Dispatcher, generated squaring lanes, collector
*/
`timescale 1ns/1ps
`default_nettype none

`include "mont_config.svh"

module mont_sq_top
  import mont_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst,
  // Job port
  input  logic       i_job_val,
  input  mont_opnd_t i_job_opnd,
  input  mont_cnt_t  i_job_cnt,
  output logic       o_job_rdy,
  // Result port
  output logic       o_res_val,
  output mont_opnd_t o_res,
  input  logic       i_res_rdy
);

  // Dispatcher side
  logic [`MONT_NUM_LANES-1:0] lane_start;
  logic [`MONT_NUM_LANES-1:0] lane_idle;
  mont_opnd_t                 bus_opnd;
  mont_cnt_t                  bus_cnt;

  // Collector side
  logic [`MONT_NUM_LANES-1:0] lane_done;
  logic [`MONT_NUM_LANES-1:0] lane_release;
  mont_opnd_t                 lane_res [`MONT_NUM_LANES];

  job_dispatch u_dispatch (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_job_val    (i_job_val),
    .i_job_opnd   (i_job_opnd),
    .i_job_cnt    (i_job_cnt),
    .i_lane_idle  (lane_idle),
    .o_job_rdy    (o_job_rdy),
    .o_lane_start (lane_start),
    .o_opnd       (bus_opnd),
    .o_cnt        (bus_cnt)
  );

  // Identical lanes on shared job buses
  for (genvar g = 0; g < `MONT_NUM_LANES; g++) begin : g_lane
    mont_sq_lane u_lane (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_start   (lane_start[g]),
      .i_opnd    (bus_opnd),
      .i_cnt     (bus_cnt),
      .i_release (lane_release[g]),
      .o_idle    (lane_idle[g]),
      .o_done    (lane_done[g]),
      .o_res     (lane_res[g])
    );
  end

  result_collect u_collect (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_lane_done    (lane_done),
    .i_lane_res     (lane_res),
    .i_res_rdy      (i_res_rdy),
    .o_lane_release (lane_release),
    .o_res_val      (o_res_val),
    .o_res          (o_res)
  );

endmodule

`default_nettype wire

/* design/result_collect.sv */
/*
  Result collector
  Drains lanes in round-robin order into a registered output
*/
`timescale 1ns/1ps
`default_nettype none

`include "mont_config.svh"

module result_collect
  import mont_pkg::*;
(
  input  logic                       i_clk,
  input  logic                       i_rst,
  input  logic [`MONT_NUM_LANES-1:0] i_lane_done,
  input  mont_opnd_t                 i_lane_res [`MONT_NUM_LANES],
  input  logic                       i_res_rdy,
  output logic [`MONT_NUM_LANES-1:0] o_lane_release,
  output logic                       o_res_val,
  output mont_opnd_t                 o_res
);

  localparam lane_idx_t LAST_LANE = lane_idx_t'(`MONT_NUM_LANES - 1);

  // Same order as the dispatcher
  lane_idx_t ptr;
  logic      res_xfer;
  logic      res_load;

  assign res_xfer = o_res_val && i_res_rdy;

  // Load only into an empty output register
  assign res_load = !o_res_val && i_lane_done[ptr];

  // Release the lane as its result leaves
  always_comb begin
    o_lane_release = '0;
    if (res_xfer) begin
      o_lane_release[ptr] = 1'b1;
    end
  end

  // Valid flag and pointer
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_res_val <= 1'b0;
      ptr       <= '0;
    end else if (res_xfer) begin
      o_res_val <= 1'b0;
      ptr       <= (ptr == LAST_LANE) ? '0 : ptr + lane_idx_t'(1);
    end else if (res_load) begin
      o_res_val <= 1'b1;
    end
  end

  // Output data, held while valid
  always_ff @(posedge i_clk) begin
    if (res_load) begin
      o_res <= i_lane_res[ptr];
    end
  end

endmodule

`default_nettype wire

/* design/word_multiplier.sv */
/*
  Single-cycle multi-mode multiplier
  Full product, low half product, or high half plus add term
  Output registered, no reset
*/
`timescale 1ns/1ps
`default_nettype none

`include "mont_config.svh"

module word_multiplier
  import mont_pkg::*;
(
  input  logic       i_clk,
  input  mult_mode_t i_mode,
  input  mont_opnd_t i_dat_a,
  input  mont_opnd_t i_dat_b,
  input  mont_opnd_t i_add_term,
  output mont_prod_t o_dat
);

  localparam int WB = `MONT_WRD_BITS;
  localparam int NW = `MONT_NUM_WRDS;
  localparam int OB = NW * WB;

  // Operands split into words
  mont_word_t wrd_a [NW];
  mont_word_t wrd_b [NW];

  // Full product and mode-selected result
  mont_prod_t prod_full;
  mont_prod_t prod_nxt;

  always_comb begin
    for (int i = 0; i < NW; i++) begin
      wrd_a[i] = i_dat_a[i*WB +: WB];
      wrd_b[i] = i_dat_b[i*WB +: WB];
    end
  end

  // Partial products summed at their word position
  always_comb begin
    logic [2*WB-1:0] part;
    prod_full = '0;
    for (int i = 0; i < NW; i++) begin
      for (int j = 0; j < NW; j++) begin
        part = wrd_a[i] * wrd_b[j];
        prod_full = prod_full + (mont_prod_t'(part) << ((i + j) * WB));
      end
    end
  end

  // Select by mode
  always_comb begin
    case (i_mode)
      SQR: begin
        prod_nxt = prod_full;
      end
      MUL_L: begin
        // Low half only, top zeroed
        prod_nxt = {{OB{1'b0}}, prod_full[OB-1:0]};
      end
      MUL_H: begin
        // High half plus add term, placed in low half
        prod_nxt = {{OB{1'b0}}, prod_full[2*OB-1:OB] + i_add_term};
      end
      default: begin
        prod_nxt = prod_full;
      end
    endcase
  end

  // Result one cycle after inputs
  always_ff @(posedge i_clk) begin
    o_dat <= prod_nxt;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/mont_pkg.sv
design/word_multiplier.sv
design/mont_sq_lane.sv
design/job_dispatch.sv
design/result_collect.sv
design/mont_sq_top.sv
verif/tb_mont_sq.sv

/* verif/tb_mont_sq.sv */
/*
  Testbench for the Montgomery squaring top level
  Clock, reset, job driver, bit-serial reference model
  Result scoreboard with random back-pressure, cycle timeout
*/
`timescale 1ns/1ps
`default_nettype none

`include "mont_config.svh"

module tb_mont_sq
  import mont_pkg::*;
();

  localparam mont_opnd_t MOD = `MONT_MODULUS;

  logic       i_clk;
  logic       i_rst;
  logic       i_job_val;
  mont_opnd_t i_job_opnd;
  mont_cnt_t  i_job_cnt;
  logic       o_job_rdy;
  logic       o_res_val;
  mont_opnd_t o_res;
  logic       i_res_rdy;

  // Expected results and test names in job order
  mont_opnd_t exp_q [$];
  string      name_q [$];

  int n_checks    = 0;
  int n_val_err   = 0;
  int n_other_err = 0;

  // Grows by 4t+8 per submitted job
  int cycles       = 0;
  int limit_cycles = 500;

  // Result-side flow control
  logic hold_rdy_low = 1'b0;
  int   stall_pct    = 0;

  mont_sq_top dut (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_job_val  (i_job_val),
    .i_job_opnd (i_job_opnd),
    .i_job_cnt  (i_job_cnt),
    .o_job_rdy  (o_job_rdy),
    .o_res_val  (o_res_val),
    .o_res      (o_res),
    .i_res_rdy  (i_res_rdy)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // Squarings in Montgomery form with bit-serial reduction
  function automatic mont_opnd_t ref_mont_pow(input mont_opnd_t a, input int unsigned t);
    logic [256:0] acc;
    mont_opnd_t   v;
    v = a;
    for (int k = 0; k < t; k++) begin
      acc = 257'(v) * 257'(v);
      for (int b = 0; b < 128; b++) begin
        if (acc[0]) begin
          acc = acc + 257'(MOD);
        end
        acc = acc >> 1;
      end
      // Below 2p here
      if (acc >= 257'(MOD)) begin
        acc = acc - 257'(MOD);
      end
      v = acc[127:0];
    end
    return v;
  endfunction

  function automatic mont_opnd_t rand_below_p();
    return {$urandom, $urandom, $urandom, $urandom} % MOD;
  endfunction

  // Entered on a falling edge and returns on the one after acceptance
  task automatic send_job(input string name, input mont_opnd_t opnd, input int unsigned cnt,
                          input mont_opnd_t exp_val);
    i_job_val  = 1'b1;
    i_job_opnd = opnd;
    i_job_cnt  = mont_cnt_t'(cnt);
    while (o_job_rdy !== 1'b1) begin
      @(negedge i_clk);
    end
    exp_q.push_back(exp_val);
    name_q.push_back(name);
    limit_cycles += 4 * int'(cnt) + 8;
    @(negedge i_clk);
    i_job_val = 1'b0;
  endtask

  task automatic check_flag(input string name, input logic exp_val, input logic act);
    n_checks++;
    assert (act === exp_val) else begin
      $display("ERR %s expected %b actual %b", name, exp_val, act);
      n_val_err++;
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(negedge i_clk);
    end
    repeat (4) @(negedge i_clk);
  endtask

  // Mode changes land mid-cycle away from the falling edge
  task automatic set_backpressure(input logic hold, input int pct);
    @(posedge i_clk);
    hold_rdy_low = hold;
    stall_pct    = pct;
    @(negedge i_clk);
  endtask

  // Result ready and scoreboard with transfer decided on the falling edge
  initial begin
    string      name;
    mont_opnd_t exp_val;
    i_res_rdy = 1'b0;
    forever begin
      @(negedge i_clk);
      if (hold_rdy_low) begin
        i_res_rdy = 1'b0;
      end else begin
        i_res_rdy = (int'($urandom % 100) >= stall_pct);
      end
      if (o_res_val === 1'b1 && i_res_rdy) begin
        assert (exp_q.size() != 0) else begin
          $display("A result came out with no job pending, value %h", o_res);
          n_other_err++;
        end
        if (exp_q.size() != 0) begin
          name    = name_q.pop_front();
          exp_val = exp_q.pop_front();
          n_checks++;
          assert (o_res === exp_val) else begin
            $display("ERR %s expected %h actual %h", name, exp_val, o_res);
            n_val_err++;
          end
        end
      end
    end
  end

  // Watchdog
  initial begin
    while (cycles <= limit_cycles) begin
      @(posedge i_clk);
      cycles++;
    end
    $display("Timeout, the run did not finish within %0d cycles", limit_cycles);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    mont_opnd_t  a;
    mont_opnd_t  mont_one;
    int unsigned t;
    int unsigned order_cnts [8];
    void'($urandom(79612));
    i_rst      = 1'b1;
    i_job_val  = 1'b0;
    i_job_opnd = '0;
    i_job_cnt  = '0;
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    @(negedge i_clk);
    check_flag("reset_res_val", 1'b0, o_res_val);
    check_flag("reset_job_rdy", 1'b1, o_job_rdy);

    // Montgomery one is R mod p and squares to itself
    mont_one = mont_opnd_t'((257'(1) << 128) % 257'(MOD));
    send_job("one_squared", mont_one, 1, mont_one);
    a = rand_below_p();
    send_job("rand_single", a, 1, ref_mont_pow(a, 1));
    wait_drain();

    a = rand_below_p();
    send_job("zero_count", a, 0, a);
    send_job("zero_count_top", MOD - 1, 0, MOD - 1);
    wait_drain();

    for (int i = 0; i < 6; i++) begin
      a = rand_below_p();
      t = $urandom % 301;
      send_job("long_chain", a, t, ref_mont_pow(a, t));
    end
    // Operands close to p
    send_job("long_chain_near_p", MOD - 1, 300, ref_mont_pow(MOD - 1, 300));
    send_job("long_chain_near_p", MOD - 2, 257, ref_mont_pow(MOD - 2, 257));
    wait_drain();

    // Long jobs first then short ones that finish early but leave in order
    order_cnts = '{200, 150, 100, 50, 3, 1, 0, 2};
    foreach (order_cnts[i]) begin
      a = rand_below_p();
      send_job("ordering", a, order_cnts[i], ref_mont_pow(a, order_cnts[i]));
    end
    wait_drain();

    // Output stalled until every lane fills up
    set_backpressure(1'b1, 0);
    for (int i = 0; i < `MONT_NUM_LANES; i++) begin
      a = rand_below_p();
      send_job("bp_fill", a, 2, ref_mont_pow(a, 2));
    end
    check_flag("bp_job_rdy_full", 1'b0, o_job_rdy);
    repeat (30) @(negedge i_clk);
    check_flag("bp_job_rdy_held", 1'b0, o_job_rdy);
    check_flag("bp_res_val_held", 1'b1, o_res_val);
    set_backpressure(1'b0, 60);
    for (int i = 0; i < 10; i++) begin
      a = rand_below_p();
      t = $urandom % 40;
      send_job("bp_random", a, t, ref_mont_pow(a, t));
    end
    wait_drain();
    set_backpressure(1'b0, 0);
    repeat (10) @(negedge i_clk);

    $display("Checks: %0d, value errors: %0d, other errors: %0d",
             n_checks, n_val_err, n_other_err);
    if (n_val_err + n_other_err == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
